// File: hw/cpuPkg.sv
package cpuPkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  regNum_t;
  typedef logic [3:0]  flags_t;   // N Z C V, with N at the top
  typedef logic [15:0] imm_t;

  // ----------------------------------------------------------------------
  // Instruction encodings
  // ----------------------------------------------------------------------
  typedef enum logic [3:0] {
    AND  = 4'd0,
    EOR  = 4'd1,
    SUB  = 4'd2,
    MOVI = 4'd3,
    ADD  = 4'd4,
    ADC  = 4'd5,
    LDR  = 4'd8,
    STR  = 4'd9,
    CMP  = 4'd10,
    ORR  = 4'd12,
    MOV  = 4'd13,
    MVN  = 4'd15
  } opCode_e;   // Codes 6, 7, 11 and 14 do nothing

  typedef enum logic [3:0] {
    EQ = 4'd0,
    NE = 4'd1,
    CS = 4'd2,
    CC = 4'd3,
    MI = 4'd4,
    PL = 4'd5,
    VS = 4'd6,
    VC = 4'd7,
    HI = 4'd8,
    LS = 4'd9,
    GE = 4'd10,
    LT = 4'd11,
    GT = 4'd12,
    LE = 4'd13,
    AL = 4'd14,
    NV = 4'd15
  } cond_e;

  typedef enum logic [1:0] {IDLE, EXEC, MEMWAIT, WRITE} ctrlState_e;

endpackage

// File: hw/memBus.sv
`timescale 1ns/1ps

interface memBus #(
  parameter int AddrWidth = 8
);

  logic                 enable;
  logic                 write;
  logic [AddrWidth-1:0] address;    // Word address
  cpuPkg::word_t        writeData;
  cpuPkg::word_t        readData;   // Valid one edge after a read enable

  modport ctrl (output enable, write, address, writeData, input readData);
  modport ram (input enable, write, address, writeData, output readData);

endinterface

// File: hw/cpuControl.sv
`timescale 1ns/1ps

module cpuControl (
  input  logic               Clk,
  input  logic               rst,
  input  logic               instrValid,
  input  cpuPkg::word_t      instruction,
  output logic               busy,
  output cpuPkg::regNum_t    regSrc1,
  output cpuPkg::regNum_t    regSrc2,
  output cpuPkg::regNum_t    regDst,
  input  cpuPkg::word_t      regData1,
  input  cpuPkg::word_t      regData2,
  output logic               regWrite,
  output cpuPkg::word_t      regWriteData,
  output cpuPkg::opCode_e    aluOp,
  output cpuPkg::word_t      aluA,
  output cpuPkg::word_t      aluB,
  output cpuPkg::imm_t       aluImm,
  input  cpuPkg::word_t      aluResult,
  input  cpuPkg::flags_t     aluFlags,
  output cpuPkg::flags_t     flags,
  output logic               timerStart,
  input  logic               timerDone,
  memBus.ctrl                mem,
  output logic               wbValid
);

  localparam int MemAw = $bits(mem.address);

  cpuPkg::ctrlState_e state;
  cpuPkg::word_t      instr;
  cpuPkg::word_t      resultQ;
  cpuPkg::word_t      addrSum;
  cpuPkg::opCode_e    op;
  cpuPkg::cond_e      cond;
  logic               condPass;
  logic               writesReg;
  logic               isMem;
  logic               memStart;
  logic               flagUpdate;

  // ----------------------------------------------------------------------
  // Instruction fields
  // ----------------------------------------------------------------------
  assign cond    = cpuPkg::cond_e'(instr[31:28]);
  assign op      = cpuPkg::opCode_e'(instr[27:24]);
  assign regDst  = instr[22:19];
  assign regSrc1 = instr[14:11];
  assign regSrc2 = (op == cpuPkg::STR) ? instr[22:19] : instr[18:15];   // STR stores dst
  assign aluImm  = instr[18:3];

  assign aluOp = op;
  assign aluA  = regData1;
  assign aluB  = regData2;
  assign busy  = (state != cpuPkg::IDLE);

  always_comb
  begin
    case (cond)
      cpuPkg::EQ: condPass = flags[2];
      cpuPkg::NE: condPass = !flags[2];
      cpuPkg::CS: condPass = flags[1];
      cpuPkg::CC: condPass = !flags[1];
      cpuPkg::MI: condPass = flags[3];
      cpuPkg::PL: condPass = !flags[3];
      cpuPkg::VS: condPass = flags[0];
      cpuPkg::VC: condPass = !flags[0];
      cpuPkg::HI: condPass = flags[1] && !flags[2];
      cpuPkg::LS: condPass = !flags[1] || flags[2];
      cpuPkg::GE: condPass = (flags[3] == flags[0]);
      cpuPkg::LT: condPass = (flags[3] != flags[0]);
      cpuPkg::GT: condPass = !flags[2] && (flags[3] == flags[0]);
      cpuPkg::LE: condPass = flags[2] || (flags[3] != flags[0]);
      cpuPkg::AL: condPass = 1'b1;
      default:    condPass = 1'b0;   // NV never runs
    endcase
  end

  always_comb
  begin
    case (op)
      cpuPkg::AND, cpuPkg::EOR, cpuPkg::SUB, cpuPkg::ADD, cpuPkg::ADC,
      cpuPkg::ORR, cpuPkg::MOV, cpuPkg::MVN, cpuPkg::MOVI: writesReg = 1'b1;
      default: writesReg = 1'b0;
    endcase
  end

  assign isMem      = (op == cpuPkg::LDR) || (op == cpuPkg::STR);
  assign memStart   = (state == cpuPkg::EXEC) && condPass && isMem;
  assign flagUpdate = condPass && ((instr[23] && writesReg) || op == cpuPkg::CMP);

  // ----------------------------------------------------------------------
  // Memory side
  // ----------------------------------------------------------------------
  assign addrSum       = regData1 + cpuPkg::word_t'(aluImm);
  assign mem.enable    = memStart || (state == cpuPkg::MEMWAIT);   // Held until the timer ends
  assign mem.write     = (op == cpuPkg::STR);
  assign mem.address   = MemAw'(addrSum);
  assign mem.writeData = regData2;
  assign timerStart    = memStart;

  assign regWrite = ((state == cpuPkg::EXEC) && condPass && writesReg) ||
                    ((state == cpuPkg::MEMWAIT) && timerDone && op == cpuPkg::LDR);

  // WRITE replays the captured value so wbData stays steady after the write
  assign regWriteData = (state == cpuPkg::WRITE)   ? resultQ :
                        (state == cpuPkg::MEMWAIT) ? mem.readData : aluResult;

  always_ff @(posedge Clk)
  begin
    if (state == cpuPkg::IDLE && instrValid)
      instr <= instruction;
    if (state != cpuPkg::WRITE)
      resultQ <= regWriteData;
  end

  always_ff @(posedge Clk)
  begin
    if (rst)
    begin
      state   <= cpuPkg::IDLE;
      flags   <= '0;
      wbValid <= 1'b0;
    end
    else
    begin
      wbValid <= regWrite;   // Pulses in the cycle after the register write
      case (state)
        cpuPkg::IDLE:
          if (instrValid)
            state <= cpuPkg::EXEC;
        cpuPkg::EXEC:
        begin
          if (flagUpdate)
            flags <= aluFlags;
          state <= memStart ? cpuPkg::MEMWAIT : cpuPkg::WRITE;
        end
        cpuPkg::MEMWAIT:
          if (timerDone)
            state <= cpuPkg::WRITE;
        default:
          state <= cpuPkg::IDLE;
      endcase
    end
  end

endmodule

// File: hw/memWaitTimer.sv
`timescale 1ns/1ps

module memWaitTimer #(
  parameter int MemLatency = 2
) (
  input  logic Clk,
  input  logic rst,
  input  logic start,
  output logic done
);

  localparam int CountWidth = (MemLatency > 1) ? $clog2(MemLatency) : 1;

  logic [CountWidth-1:0] count;
  logic                  running;

  always_ff @(posedge Clk)
  begin
    if (rst)
    begin
      count   <= '0;
      running <= 1'b0;
    end
    else if (start)
    begin
      count   <= CountWidth'(MemLatency - 1);   // Reaches zero in the last held cycle
      running <= 1'b1;
    end
    else if (running)
    begin
      if (count == '0)
        running <= 1'b0;
      else
        count <= count - 1'b1;
    end
  end

  assign done = running && (count == '0);

endmodule

// File: hw/registerBank.sv
`timescale 1ns/1ps

module registerBank (
  input  logic            Clk,
  input  logic            rst,
  input  cpuPkg::regNum_t src1,
  input  cpuPkg::regNum_t src2,
  input  cpuPkg::regNum_t dst,
  input  logic            writeEnable,
  input  cpuPkg::word_t   writeData,
  output cpuPkg::word_t   data1,
  output cpuPkg::word_t   data2
);

  cpuPkg::word_t regs [16];

  always_ff @(posedge Clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < 16; i++)
        regs[i] <= '0;
    end
    else if (writeEnable)
    begin
      regs[dst] <= writeData;
    end
  end

  // Both read ports see the array directly
  assign data1 = regs[src1];
  assign data2 = regs[src2];

endmodule

// File: hw/masterAlu.sv
`timescale 1ns/1ps

module masterAlu (
  input  cpuPkg::opCode_e op,
  input  cpuPkg::word_t   a,
  input  cpuPkg::word_t   b,
  input  cpuPkg::imm_t    imm,
  input  logic            carryIn,
  output cpuPkg::word_t   result,
  output cpuPkg::flags_t  newFlags
);

  cpuPkg::word_t addB;
  cpuPkg::word_t sum;
  logic          isSub;
  logic          addCin;
  logic          carryOut;
  logic          overflow;
  logic          useAdder;

  // ----------------------------------------------------------------------
  // Shared adder, subtraction runs as a + ~b + 1
  // ----------------------------------------------------------------------
  assign isSub  = (op == cpuPkg::SUB) || (op == cpuPkg::CMP);
  assign addB   = isSub ? ~b : b;
  assign addCin = isSub ? 1'b1 : ((op == cpuPkg::ADC) ? carryIn : 1'b0);

  assign {carryOut, sum} = {1'b0, a} + {1'b0, addB} + {32'b0, addCin};

  // Both inputs share a sign that the result does not
  assign overflow = (a[31] == addB[31]) && (sum[31] != a[31]);

  always_comb
  begin
    result   = '0;
    useAdder = 1'b0;
    case (op)
      cpuPkg::AND:  result = a & b;
      cpuPkg::EOR:  result = a ^ b;
      cpuPkg::ORR:  result = a | b;
      cpuPkg::MOV:  result = b;
      cpuPkg::MVN:  result = ~b;
      cpuPkg::MOVI: result = cpuPkg::word_t'(imm);
      cpuPkg::SUB, cpuPkg::ADD, cpuPkg::ADC, cpuPkg::CMP:
      begin
        result   = sum;
        useAdder = 1'b1;
      end
      default:      result = '0;
    endcase
  end

  // Logical ops keep the carry and clear V
  assign newFlags = {result[31],
                     (result == '0),
                     useAdder ? carryOut : carryIn,
                     useAdder ? overflow : 1'b0};

endmodule

// File: hw/dataRam.sv
`timescale 1ns/1ps

module dataRam #(
  parameter int AddrWidth = 8
) (
  input logic Clk,
  memBus.ram  mem
);

  localparam int Depth = 1 << AddrWidth;

  cpuPkg::word_t words [Depth];

  always_ff @(posedge Clk)
  begin
    if (mem.enable)
    begin
      if (mem.write)
        words[mem.address] <= mem.writeData;
      else
        mem.readData <= words[mem.address];   // Registered read
    end
  end

endmodule

// File: hw/cpuTop.sv
`timescale 1ns/1ps

module cpuTop #(
  parameter int AddrWidth  = 8,
  parameter int MemLatency = 2
) (
  input  logic            Clk,
  input  logic            rst,
  input  logic            instrValid,
  input  cpuPkg::word_t   instruction,
  output logic            busy,
  output logic            wbValid,
  output cpuPkg::regNum_t wbReg,
  output cpuPkg::word_t   wbData,
  output cpuPkg::flags_t  flags
);

  cpuPkg::regNum_t regSrc1;
  cpuPkg::regNum_t regSrc2;
  cpuPkg::word_t   regData1;
  cpuPkg::word_t   regData2;
  logic            regWrite;
  cpuPkg::opCode_e aluOp;
  cpuPkg::word_t   aluA;
  cpuPkg::word_t   aluB;
  cpuPkg::imm_t    aluImm;
  cpuPkg::word_t   aluResult;
  cpuPkg::flags_t  aluFlags;
  logic            timerStart;
  logic            timerDone;

  memBus #(.AddrWidth(AddrWidth)) memIf ();

  cpuControl control (
    .Clk(Clk), .rst(rst), .instrValid(instrValid), .instruction(instruction), .busy(busy),
    .regSrc1(regSrc1), .regSrc2(regSrc2), .regDst(wbReg),
    .regData1(regData1), .regData2(regData2), .regWrite(regWrite), .regWriteData(wbData),
    .aluOp(aluOp), .aluA(aluA), .aluB(aluB), .aluImm(aluImm),
    .aluResult(aluResult), .aluFlags(aluFlags), .flags(flags),
    .timerStart(timerStart), .timerDone(timerDone), .mem(memIf), .wbValid(wbValid)
  );

  memWaitTimer #(.MemLatency(MemLatency)) timer (
    .Clk(Clk), .rst(rst), .start(timerStart), .done(timerDone)
  );

  registerBank regs (
    .Clk(Clk), .rst(rst), .src1(regSrc1), .src2(regSrc2), .dst(wbReg),
    .writeEnable(regWrite), .writeData(wbData), .data1(regData1), .data2(regData2)
  );

  masterAlu alu (
    .op(aluOp), .a(aluA), .b(aluB), .imm(aluImm), .carryIn(flags[1]),
    .result(aluResult), .newFlags(aluFlags)
  );

  dataRam #(.AddrWidth(AddrWidth)) ram (
    .Clk(Clk), .mem(memIf)
  );

endmodule

// File: bench/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;

  localparam int AddrWidth     = 8;   // The LDR immediates below assume 8 address bits
  localparam int MemLatency    = 3;
  localparam int NumRandom     = 200;
  localparam int CondRounds    = 12;
  localparam int NumMem        = 16;
  localparam int NumInstr      = 16 + NumRandom + CondRounds * 17 + 2 * NumMem + 2;
  localparam int TimeoutCycles = NumInstr * (4 + MemLatency) + 100;
  localparam logic [31:0] AddrMask = 32'((1 << AddrWidth) - 1);

  logic            Clk = 1'b0;
  logic            rst = 1'b1;
  logic            instrValid = 1'b0;
  cpuPkg::word_t   instruction = '0;
  logic            busy;
  logic            wbValid;
  cpuPkg::regNum_t wbReg;
  cpuPkg::word_t   wbData;
  cpuPkg::flags_t  flags;

  // Reference model state and the writebacks it still expects
  cpuPkg::word_t   mRegs [16];
  cpuPkg::flags_t  mFlags = '0;
  cpuPkg::word_t   mRam [int unsigned];
  logic [3:0]      expRegQ [$];
  cpuPkg::word_t   expDataQ [$];
  logic [31:0]     expCycleQ [$];
  logic [31:0]     expBusyEnd = '0;
  logic [31:0]     cycle = '0;
  logic [31:0]     rng = 32'h12df_4bcb;
  logic            busyQ = 1'b0;
  int              errorCount = 0;
  int              checkCount = 0;
  logic [3:0]      aluOps [11] = '{cpuPkg::AND, cpuPkg::EOR, cpuPkg::SUB, cpuPkg::ADD,
                                   cpuPkg::ADC, cpuPkg::ADC, cpuPkg::ORR, cpuPkg::MOV,
                                   cpuPkg::MVN, cpuPkg::CMP, 4'd11};

  cpuTop #(.AddrWidth(AddrWidth), .MemLatency(MemLatency)) DUT (
    .Clk(Clk), .rst(rst), .instrValid(instrValid), .instruction(instruction), .busy(busy),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .flags(flags)
  );

  always #2 Clk = ~Clk;

  always @(posedge Clk)
  begin
    cycle <= cycle + 1;
    if (cycle == TimeoutCycles)
    begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic condHolds(input logic [3:0] cond, input cpuPkg::flags_t f);
    case (cond)
      cpuPkg::EQ: return f[2];
      cpuPkg::NE: return !f[2];
      cpuPkg::CS: return f[1];
      cpuPkg::CC: return !f[1];
      cpuPkg::MI: return f[3];
      cpuPkg::PL: return !f[3];
      cpuPkg::VS: return f[0];
      cpuPkg::VC: return !f[0];
      cpuPkg::HI: return f[1] && !f[2];
      cpuPkg::LS: return !f[1] || f[2];
      cpuPkg::GE: return f[3] == f[0];
      cpuPkg::LT: return f[3] != f[0];
      cpuPkg::GT: return !f[2] && (f[3] == f[0]);
      cpuPkg::LE: return f[2] || (f[3] != f[0]);
      cpuPkg::AL: return 1'b1;
      default:    return 1'b0;
    endcase
  endfunction

  function automatic cpuPkg::word_t encode(input logic [3:0] cond, input logic [3:0] op,
                                           input logic s, input logic [3:0] dst,
                                           input logic [3:0] src2, input logic [3:0] src1);
    return {cond, op, s, dst, src2, src1, 11'b0};
  endfunction

  // The immediate covers source2 and source1 as well
  function automatic cpuPkg::word_t encodeImm(input logic [3:0] cond, input logic [3:0] op,
                                              input logic s, input logic [3:0] dst,
                                              input cpuPkg::imm_t imm);
    return {cond, op, s, dst, imm, 3'b0};
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    if (got !== exp)
    begin
      errorCount++;
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // -------------------------------------------------------------------
  // Reference model, run once per accepted instruction
  // -------------------------------------------------------------------
  function automatic void model(input cpuPkg::word_t ins, input logic [31:0] driveCycle);
    logic [3:0]    op;
    logic [3:0]    dst;
    logic          c;
    logic          v;
    logic          writes;
    cpuPkg::imm_t  imm;
    cpuPkg::word_t a;
    cpuPkg::word_t b;
    cpuPkg::word_t res;
    logic [32:0]   wide;
    logic [31:0]   addr;
    op     = ins[27:24];
    dst    = ins[22:19];
    imm    = ins[18:3];
    a      = mRegs[ins[14:11]];
    b      = mRegs[ins[18:15]];
    addr   = (a + {16'b0, imm}) & AddrMask;
    c      = mFlags[1];
    v      = 1'b0;
    writes = 1'b1;
    res    = '0;
    expBusyEnd = driveCycle + 32'd4;   // Busy drops two edges after acceptance
    if (!condHolds(ins[31:28], mFlags))
      return;
    if (op == cpuPkg::LDR || op == cpuPkg::STR)
      expBusyEnd = expBusyEnd + 32'(MemLatency);
    case (op)
      cpuPkg::AND:  res = a & b;
      cpuPkg::EOR:  res = a ^ b;
      cpuPkg::ORR:  res = a | b;
      cpuPkg::MOV:  res = b;
      cpuPkg::MVN:  res = ~b;
      cpuPkg::MOVI: res = {16'b0, imm};
      cpuPkg::ADD, cpuPkg::ADC:
      begin
        wide = {1'b0, a} + {1'b0, b} + {32'b0, (op == cpuPkg::ADC) && mFlags[1]};
        res  = wide[31:0];
        c    = wide[32];
        v    = (a[31] == b[31]) && (res[31] != a[31]);
      end
      cpuPkg::SUB, cpuPkg::CMP:
      begin
        res    = a - b;
        c      = (a >= b);   // Carry means no borrow
        v      = (a[31] != b[31]) && (res[31] != a[31]);
        writes = (op == cpuPkg::SUB);
      end
      cpuPkg::LDR:  res = mRam.exists(addr) ? mRam[addr] : 'x;
      cpuPkg::STR:
      begin
        mRam[addr] = mRegs[dst];
        writes     = 1'b0;
      end
      default:      writes = 1'b0;
    endcase
    if (op == cpuPkg::CMP || (ins[23] && writes && op != cpuPkg::LDR))
      mFlags = {res[31], res == 32'd0, c, v};
    if (writes)
    begin
      mRegs[dst] = res;
      expRegQ.push_back(dst);
      expDataQ.push_back(res);
      // Accepted one edge after driving, wbValid seen after the next edge
      expCycleQ.push_back(driveCycle + 32'd3 + ((op == cpuPkg::LDR) ? 32'(MemLatency) : 32'd0));
    end
  endfunction

  task automatic issue(input cpuPkg::word_t ins, input logic pulseWhileBusy,
                       input cpuPkg::word_t spurious);
    @(posedge Clk);
    model(ins, cycle);
    instrValid  <= 1'b1;
    instruction <= ins;
    @(posedge Clk);
    instrValid <= 1'b0;
    if (pulseWhileBusy)
    begin
      @(posedge Clk);
      instrValid  <= 1'b1;
      instruction <= spurious;
      @(posedge Clk);
      instrValid <= 1'b0;
    end
    do
      @(negedge Clk);
    while (busy);
  endtask

  // -------------------------------------------------------------------
  // Checker
  // -------------------------------------------------------------------
  always @(negedge Clk)
  begin
    if (rst)
      busyQ = 1'b0;
    else
    begin
      if (wbValid && expRegQ.size() == 0)
      begin
        errorCount++;
        $display("Writeback to r%0d at %0t was not expected", wbReg, $time);
      end
      else if (wbValid)
      begin
        check("wbReg", {28'b0, wbReg}, {28'b0, expRegQ.pop_front()});
        check("wbData", wbData, expDataQ.pop_front());
        check("wbValid cycle", cycle, expCycleQ.pop_front());
      end
      if (busyQ && !busy)
      begin
        check("busy fall cycle", cycle, expBusyEnd);
        check("flags", {28'b0, flags}, {28'b0, mFlags});
        if (expRegQ.size() != 0)
        begin
          errorCount++;
          $display("Writeback to r%0d never arrived before %0t", expRegQ[0], $time);
          expRegQ.delete();
          expDataQ.delete();
          expCycleQ.delete();
        end
      end
      busyQ = busy;
    end
  end

  initial
  begin
    logic [3:0]   opSel;
    logic [3:0]   op;
    logic [3:0]   src1;
    logic [3:0]   src2;
    logic [31:0]  low;
    cpuPkg::imm_t imm;
    logic [31:0]  addrList [$];
    for (int i = 0; i < 16; i++)
      mRegs[i] = '0;
    repeat (8) @(posedge Clk);
    rst <= 1'b0;

    for (int i = 0; i < 16; i++)
      issue(encodeImm(cpuPkg::AL, cpuPkg::MOVI, 1'b0, 4'(i), 16'h9E37 ^ (16'(i) * 16'h1111)),
            1'b0, '0);

    for (int i = 0; i < NumRandom; i++)
    begin
      rng   = xorshift(rng);
      opSel = 4'(rng % 11);
      issue(encode(cpuPkg::AL, aluOps[opSel], rng[20], rng[3:0], rng[7:4], rng[11:8]), 1'b0, '0);
    end

    // Every condition code against the flags left by one CMP
    for (int r = 0; r < CondRounds; r++)
    begin
      rng  = xorshift(rng);
      src1 = rng[3:0];
      src2 = (r % 4 == 0) ? src1 : rng[7:4];
      issue(encode(cpuPkg::AL, cpuPkg::CMP, 1'b0, 4'd0, src2, src1), 1'b0, '0);
      for (int c = 0; c < 16; c++)
      begin
        rng = xorshift(rng);
        op  = (c % 3 == 0) ? cpuPkg::ADD : ((c % 3 == 1) ? cpuPkg::EOR : cpuPkg::MOV);
        issue(encode(4'(c), op, 1'b0, rng[3:0], rng[7:4], rng[11:8]), 1'b0, '0);
      end
    end

    for (int i = 0; i < NumMem; i++)
    begin
      rng = xorshift(rng);
      imm = rng[19:4];
      addrList.push_back((mRegs[imm[11:8]] + {16'b0, imm}) & AddrMask);
      issue(encodeImm(cpuPkg::AL, cpuPkg::STR, 1'b0, rng[23:20], imm), 1'b0, '0);
    end
    for (int i = 0; i < NumMem; i++)
    begin
      rng  = xorshift(rng);
      src1 = rng[3:0];
      low  = addrList[i] - mRegs[src1];
      imm  = {rng[15:12], src1, low[7:0]};   // Bits 11 to 8 double as source1
      issue(encodeImm(cpuPkg::AL, cpuPkg::LDR, rng[16], rng[7:4], imm), 1'b0, '0);
    end

    issue(encode(cpuPkg::AL, cpuPkg::ADD, 1'b0, 4'd5, 4'd6, 4'd7), 1'b1,
          encodeImm(cpuPkg::AL, cpuPkg::MOVI, 1'b0, 4'd3, 16'hBEEF));
    issue(encode(cpuPkg::AL, cpuPkg::MOV, 1'b0, 4'd3, 4'd3, 4'd0), 1'b0, '0);

    @(posedge Clk);
    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

// File: src.f
hw/cpuPkg.sv
hw/memBus.sv
hw/cpuControl.sv
hw/memWaitTimer.sv
hw/registerBank.sv
hw/masterAlu.sv
hw/dataRam.sv
hw/cpuTop.sv
bench/cpuTb.sv

// File: Makefile
# Verilator build and run for the multicycle core testbench

VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TB PASSED'

clean:
	rm -rf $(OBJ_DIR)
